/* Bender.yml */
package:
  name: serial_node

sources:
  - hw/noc_pkg.sv
  - hw/baud_gen.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/flit_fifo.sv
  - hw/router_core.sv
  - hw/serial_node.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/serial_node_tb.sv

/* hw/baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_gen #(
	parameter logic [11:0] BAUD_FREQ = 12'd288,
	parameter logic [15:0] BAUD_LIMIT = 16'd15625
) (
	input wire CLK,
	input wire RST_N,
	output logic ce_16
);

	logic [16:0] acc;
	logic [16:0] acc_sum;

	// one spare bit so the sum cannot wrap
	assign acc_sum = acc + 17'(BAUD_FREQ);

	always_ff @(posedge CLK)
	begin
		if (RST_N)
		begin
			acc <= '0;
			ce_16 <= 1'b0;
		end
		else if (acc_sum >= 17'(BAUD_LIMIT))
		begin
			acc <= acc_sum - 17'(BAUD_LIMIT);
			ce_16 <= 1'b1;
		end
		else
		begin
			acc <= acc_sum;
			ce_16 <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
	parameter int DEPTH = 4
) (
	input wire CLK,
	input wire RST_N,
	input wire push,
	input wire noc_pkg::flit_t push_flit,
	input wire pop,
	output noc_pkg::flit_t head,
	output logic empty,
	output logic full
);
	import noc_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign head = mem[rd_ptr];

	always_ff @(posedge CLK)
	begin
		if (RST_N)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

endmodule

`default_nettype wire

/* hw/noc_pkg.sv */
`default_nettype none

package noc_pkg;

	// field widths of a flit, which matches the serial word bit for bit
	localparam int DEST_W = 2;
	localparam int PAYLOAD_W = 14;
	localparam int WORD_W = DEST_W + PAYLOAD_W;

	localparam int NUM_DEST = 4;

	// receive clock enable pulses per serial bit
	localparam int OVERSAMPLE = 16;

	typedef logic [DEST_W-1:0] dest_t;

	typedef enum logic
	{
		PORT_LOCAL = 1'b0,
		PORT_SERIAL = 1'b1
	} port_t;

	// dest sits in the two upper bits
	typedef struct packed
	{
		dest_t dest;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// indexed by destination
	typedef port_t [NUM_DEST-1:0] route_map_t;

endpackage

`default_nettype wire

/* hw/router_core.sv */
`timescale 1ns/1ps
`default_nettype none

module router_core #(
	parameter noc_pkg::route_map_t ROUTE_MAP =
		'{1: noc_pkg::PORT_LOCAL, default: noc_pkg::PORT_SERIAL},
	parameter int BUF_DEPTH = 4,
	parameter int EJECT_DEPTH = 4
) (
	input wire CLK,
	input wire RST_N,
	input wire inject_valid,
	input wire noc_pkg::flit_t inject_flit,
	output logic inject_credit,
	input wire rx_valid,
	input wire noc_pkg::flit_t rx_word,
	output logic eject_valid,
	output noc_pkg::flit_t eject_flit,
	input wire eject_credit,
	output logic tx_start,
	output noc_pkg::flit_t tx_flit,
	input wire tx_busy,
	input wire ser_ready
);
	import noc_pkg::*;

	localparam int IN_LOCAL = 0;
	localparam int IN_SERIAL = 1;
	localparam int CNT_W = $clog2(EJECT_DEPTH + 1);

	flit_t buf_head [2];
	logic [1:0] buf_empty;
	logic [1:0] buf_full;
	logic [1:0] buf_pop;
	port_t [1:0] head_port;
	logic [1:0] out_ready;
	// indexed [output][input]
	logic [1:0][1:0] req;
	logic [1:0][1:0] gnt;
	// per output, the input that wins a tie
	logic [1:0] prio;
	logic [CNT_W-1:0] eject_cnt;

	function automatic logic [1:0] rr_pick(input logic [1:0] r, input logic p);
		if (&r)
			return 2'b01 << p;
		return r;
	endfunction

	flit_fifo #(.DEPTH(BUF_DEPTH)) local_buf (
		.CLK(CLK),
		.RST_N(RST_N),
		.push(inject_valid),
		.push_flit(inject_flit),
		.pop(buf_pop[IN_LOCAL]),
		.head(buf_head[IN_LOCAL]),
		.empty(buf_empty[IN_LOCAL]),
		.full(buf_full[IN_LOCAL])
	);

	// no back-pressure on the link, overflow words are dropped
	flit_fifo #(.DEPTH(BUF_DEPTH)) serial_buf (
		.CLK(CLK),
		.RST_N(RST_N),
		.push(rx_valid && !buf_full[IN_SERIAL]),
		.push_flit(rx_word),
		.pop(buf_pop[IN_SERIAL]),
		.head(buf_head[IN_SERIAL]),
		.empty(buf_empty[IN_SERIAL]),
		.full(buf_full[IN_SERIAL])
	);

	always_comb
	begin
		out_ready[PORT_LOCAL] = (eject_cnt != '0);
		// tx_busy lags tx_start by a cycle
		out_ready[PORT_SERIAL] = !tx_busy && ser_ready && !tx_start;
		for (int i = 0; i < 2; i++)
			head_port[i] = ROUTE_MAP[buf_head[i].dest];
		for (int o = 0; o < 2; o++)
		begin
			for (int i = 0; i < 2; i++)
				req[o][i] = !buf_empty[i] && (head_port[i] == port_t'(o)) && out_ready[o];
			gnt[o] = rr_pick(req[o], prio[o]);
		end
		buf_pop = gnt[PORT_LOCAL] | gnt[PORT_SERIAL];
	end

	always_ff @(posedge CLK)
	begin
		if (RST_N)
		begin
			eject_valid <= 1'b0;
			tx_start <= 1'b0;
			inject_credit <= 1'b0;
			prio <= '0;
			eject_cnt <= CNT_W'(EJECT_DEPTH);
		end
		else
		begin
			eject_valid <= |gnt[PORT_LOCAL];
			tx_start <= |gnt[PORT_SERIAL];
			inject_credit <= buf_pop[IN_LOCAL];
			// the other input goes first next time
			for (int o = 0; o < 2; o++)
				if (|gnt[o])
					prio[o] <= !gnt[o][IN_SERIAL];
			case ({|gnt[PORT_LOCAL], eject_credit})
				2'b10: eject_cnt <= eject_cnt - 1'b1;
				2'b01: eject_cnt <= eject_cnt + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (|gnt[PORT_LOCAL])
			eject_flit <= gnt[PORT_LOCAL][IN_SERIAL] ? buf_head[IN_SERIAL] : buf_head[IN_LOCAL];
		if (|gnt[PORT_SERIAL])
			tx_flit <= gnt[PORT_SERIAL][IN_SERIAL] ? buf_head[IN_SERIAL] : buf_head[IN_LOCAL];
	end

endmodule

`default_nettype wire

/* hw/serial_node.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_node #(
	parameter noc_pkg::route_map_t ROUTE_MAP =
		'{1: noc_pkg::PORT_LOCAL, default: noc_pkg::PORT_SERIAL},
	parameter int BUF_DEPTH = 4,
	parameter int EJECT_DEPTH = 4,
	// 100 MHz clock and 115200 baud
	parameter logic [11:0] BAUD_FREQ = 12'd288,
	parameter logic [15:0] BAUD_LIMIT = 16'd15625
) (
	input wire CLK,
	input wire RST_N,
	input wire inject_valid,
	input wire noc_pkg::flit_t inject_flit,
	output logic inject_credit,
	output logic eject_valid,
	output noc_pkg::flit_t eject_flit,
	input wire eject_credit,
	input wire ser_in,
	output logic ser_out,
	input wire ser_ready
);
	import noc_pkg::*;

	logic ce_16;
	logic rx_valid;
	flit_t rx_word;
	logic tx_start;
	flit_t tx_flit;
	logic tx_busy;

	baud_gen #(
		.BAUD_FREQ(BAUD_FREQ),
		.BAUD_LIMIT(BAUD_LIMIT)
	) baud_gen_0 (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce_16(ce_16)
	);

	uart_rx uart_rx_0 (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce_16(ce_16),
		.ser_in(ser_in),
		.rx_valid(rx_valid),
		.rx_word(rx_word)
	);

	uart_tx uart_tx_0 (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce_16(ce_16),
		.tx_start(tx_start),
		.tx_flit(tx_flit),
		.tx_busy(tx_busy),
		.ser_out(ser_out)
	);

	router_core #(
		.ROUTE_MAP(ROUTE_MAP),
		.BUF_DEPTH(BUF_DEPTH),
		.EJECT_DEPTH(EJECT_DEPTH)
	) router_core_0 (
		.CLK(CLK),
		.RST_N(RST_N),
		.inject_valid(inject_valid),
		.inject_flit(inject_flit),
		.inject_credit(inject_credit),
		.rx_valid(rx_valid),
		.rx_word(rx_word),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit),
		.eject_credit(eject_credit),
		.tx_start(tx_start),
		.tx_flit(tx_flit),
		.tx_busy(tx_busy),
		.ser_ready(ser_ready)
	);

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire CLK,
	input wire RST_N,
	input wire ce_16,
	input wire ser_in,
	output logic rx_valid,
	output noc_pkg::flit_t rx_word
);
	import noc_pkg::*;

	localparam int SAMPLE_W = $clog2(OVERSAMPLE);
	localparam int BIT_W = $clog2(WORD_W);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic [1:0] sync_q;
	logic [SAMPLE_W-1:0] sample_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [WORD_W-1:0] shift_q;
	logic rx_bit;
	logic mid_bit;

	// line idles high
	always_ff @(posedge CLK)
	begin
		if (RST_N)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], ser_in};
	end

	assign rx_bit = sync_q[1];

	// start bit is checked half a bit in, every later bit one full bit apart
	assign mid_bit = ce_16 && ((state == RX_START) ?
		(sample_cnt == SAMPLE_W'(OVERSAMPLE / 2 - 1)) :
		(sample_cnt == SAMPLE_W'(OVERSAMPLE - 1)));

	always_ff @(posedge CLK)
	begin
		if (RST_N)
		begin
			state <= RX_IDLE;
			sample_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (ce_16 && state != RX_IDLE)
				sample_cnt <= mid_bit ? '0 : sample_cnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					if (!rx_bit)
					begin
						state <= RX_START;
						sample_cnt <= '0;
					end
				end
				RX_START:
				begin
					if (mid_bit)
					begin
						// high again means a glitch, not a start
						state <= rx_bit ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
				end
				RX_DATA:
				begin
					if (mid_bit)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(WORD_W - 1))
							state <= RX_STOP;
					end
				end
				default:
				begin
					// bad stop bit drops the word
					if (mid_bit)
					begin
						rx_valid <= rx_bit;
						state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge CLK)
	begin
		if (state == RX_DATA && mid_bit)
			shift_q <= {rx_bit, shift_q[WORD_W-1:1]};
		if (state == RX_STOP && mid_bit && rx_bit)
			rx_word <= flit_t'(shift_q);
	end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire CLK,
	input wire RST_N,
	input wire ce_16,
	input wire tx_start,
	input wire noc_pkg::flit_t tx_flit,
	output logic tx_busy,
	output logic ser_out
);
	import noc_pkg::*;

	// start bit, data word, stop bit
	localparam int FRAME_W = WORD_W + 2;
	localparam int SAMPLE_W = $clog2(OVERSAMPLE);
	localparam int BIT_W = $clog2(FRAME_W);

	logic [FRAME_W-1:0] frame_q;
	logic [SAMPLE_W-1:0] sample_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic bit_end;

	assign bit_end = ce_16 && (sample_cnt == SAMPLE_W'(OVERSAMPLE - 1));

	always_ff @(posedge CLK)
	begin
		if (RST_N)
		begin
			tx_busy <= 1'b0;
			sample_cnt <= '0;
			bit_cnt <= '0;
			ser_out <= 1'b1;
		end
		else
		begin
			ser_out <= tx_busy ? frame_q[0] : 1'b1;
			if (!tx_busy)
			begin
				if (tx_start)
				begin
					tx_busy <= 1'b1;
					sample_cnt <= '0;
					bit_cnt <= '0;
				end
			end
			else if (ce_16)
			begin
				sample_cnt <= sample_cnt + 1'b1;
				if (bit_end)
				begin
					bit_cnt <= bit_cnt + 1'b1;
					// stop bit done
					if (bit_cnt == BIT_W'(FRAME_W - 1))
						tx_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!tx_busy && tx_start)
			frame_q <= {1'b1, tx_flit, 1'b0};
		else if (tx_busy && bit_end)
			frame_q <= {1'b1, frame_q[FRAME_W-1:1]};
	end

endmodule

`default_nettype wire

/* include/serial_node_tb_tasks.svh */
`ifndef SERIAL_NODE_TB_TASKS_SVH
`define SERIAL_NODE_TB_TASKS_SVH

// start bit, word lsb first, stop bit
task automatic send_frame(input flit_t word);
	logic [WORD_W+1:0] frame;
	int i;
	frame = {1'b1, word, 1'b0};
	for (i = 0; i < WORD_W + 2; i++)
	begin
		ser_in = frame[i];
		repeat (BIT_CYCLES) @(posedge CLK);
		#1;
	end
endtask

// every bit sampled at its middle
task automatic decode_frame(output flit_t word, output bit framed);
	logic [WORD_W-1:0] bits;
	int i;
	do
	begin
		@(negedge CLK);
	end
	while (ser_out !== 1'b0);
	repeat (BIT_CYCLES / 2) @(negedge CLK);
	framed = (ser_out === 1'b0);
	for (i = 0; i < WORD_W; i++)
	begin
		repeat (BIT_CYCLES) @(negedge CLK);
		bits[i] = ser_out;
	end
	repeat (BIT_CYCLES) @(negedge CLK);
	framed = framed && (ser_out === 1'b1);
	word = flit_t'(bits);
endtask

// eject receiver, one credit back per flit after credit_delay cycles
task automatic run_eject_receiver();
	int wait_cnt;
	wait_cnt = 0;
	eject_credit = 1'b0;
	forever
	begin
		@(posedge CLK);
		#1;
		eject_credit = 1'b0;
		if (owed > 0 && !credit_hold)
		begin
			if (wait_cnt >= credit_delay)
			begin
				eject_credit = 1'b1;
				owed--;
				wait_cnt = 0;
			end
			else
				wait_cnt++;
		end
	end
endtask

`endif

/* verification/serial_node_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_node_tb;
	import noc_pkg::*;

	localparam route_map_t ROUTE_MAP = '{1: PORT_LOCAL, default: PORT_SERIAL};
	localparam int BUF_DEPTH = 4;
	localparam int EJECT_DEPTH = 2;
	localparam logic [11:0] BAUD_FREQ = 12'd1;
	localparam logic [15:0] BAUD_LIMIT = 16'd2;
	localparam int BIT_CYCLES = OVERSAMPLE * int'(BAUD_LIMIT) / int'(BAUD_FREQ);
	localparam int NUM_ENTRIES = 20;
	localparam int TIMEOUT_CYCLES = 2 * NUM_ENTRIES * 600;
	localparam bit SRC_LOCAL = 1'b0;

	// {source, dest} with source 1 for the serial link
	localparam logic [2:0] SRC_DEST [NUM_ENTRIES] = '{
		3'b001, 3'b001, 3'b000, 3'b010, 3'b101, 3'b111, 3'b011, 3'b101, 3'b100, 3'b001,
		3'b110, 3'b010,
		3'b000, 3'b010, 3'b011, 3'b000,
		3'b001, 3'b001, 3'b001, 3'b001
	};

	typedef struct packed
	{
		logic src;
		flit_t flit;
	} entry_t;

	logic CLK;
	logic RST_N;
	logic inject_valid;
	flit_t inject_flit;
	logic inject_credit;
	logic eject_valid;
	flit_t eject_flit;
	logic eject_credit;
	logic ser_in;
	logic ser_out;
	logic ser_ready;

	entry_t stim [NUM_ENTRIES];
	// entry indices by 2 * port + source
	int exp_q [4][$];
	int seed;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycles = 0;
	int owed = 0;
	int ejected = 0;
	int inj_credits;
	int credit_pulses = 0;
	int local_sent = 0;
	int credit_delay;
	bit credit_hold;

	`include "serial_node_tb_tasks.svh"

	serial_node #(
		.ROUTE_MAP(ROUTE_MAP),
		.BUF_DEPTH(BUF_DEPTH),
		.EJECT_DEPTH(EJECT_DEPTH),
		.BAUD_FREQ(BAUD_FREQ),
		.BAUD_LIMIT(BAUD_LIMIT)
	) UUT (
		.CLK(CLK),
		.RST_N(RST_N),
		.inject_valid(inject_valid),
		.inject_flit(inject_flit),
		.inject_credit(inject_credit),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit),
		.eject_credit(eject_credit),
		.ser_in(ser_in),
		.ser_out(ser_out),
		.ser_ready(ser_ready)
	);

	task automatic check(input bit cond, input string msg);
		checks++;
		assert (cond)
		else
		begin
			$display("Fail at %0d ns: %s", $time, msg);
			errors++;
		end
	endtask

	// must match the oldest pending flit of one source
	task automatic match_arrival(input int port, input flit_t f);
		int s;
		int ch;
		bit hit;
		hit = 1'b0;
		for (s = 0; s < 2; s++)
		begin
			ch = 2 * port + s;
			if (!hit && exp_q[ch].size() > 0 && stim[exp_q[ch][0]].flit == f)
			begin
				void'(exp_q[ch].pop_front());
				hit = 1'b1;
			end
		end
		check(hit, $sformatf("unexpected flit %h on %s port", f, port ? "serial" : "local"));
	endtask

	task automatic send_local(input flit_t f);
		while (inj_credits == 0)
		begin
			@(posedge CLK);
			#1;
		end
		inj_credits--;
		local_sent++;
		inject_flit = f;
		inject_valid = 1'b1;
		@(posedge CLK);
		#1;
		inject_valid = 1'b0;
	endtask

	task automatic apply_entries(input int first, input int last);
		int i;
		int ch;
		for (i = first; i <= last; i++)
		begin
			ch = 2 * int'(ROUTE_MAP[stim[i].flit.dest]) + int'(stim[i].src);
			exp_q[ch].push_back(i);
			if (stim[i].src == SRC_LOCAL)
				send_local(stim[i].flit);
			else
				send_frame(stim[i].flit);
		end
	endtask

	task automatic wait_drained();
		while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() > 0
			|| owed > 0)
		begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic report_test(input string name, input int err_mark);
		tests++;
		if (errors == err_mark)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_mark);
	endtask

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles with flits still outstanding", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	always @(negedge CLK)
	begin
		if (!RST_N && eject_valid)
		begin
			ejected++;
			owed++;
			check(owed <= EJECT_DEPTH, "flit ejected without a credit");
			match_arrival(int'(PORT_LOCAL), eject_flit);
		end
		if (!RST_N && inject_credit)
		begin
			inj_credits++;
			credit_pulses++;
			check(inj_credits <= BUF_DEPTH, "more inject credits than flits sent");
		end
	end

	initial
		run_eject_receiver();

	initial
	begin
		flit_t word;
		bit framed;
		@(negedge RST_N);
		forever
		begin
			decode_frame(word, framed);
			check(framed, "framing error on ser_out");
			match_arrival(int'(PORT_SERIAL), word);
		end
	end

	initial
	begin
		int i;
		int err_mark;
		int eject_mark;
		logic [31:0] rnd;
		RST_N = 1'b1;
		inject_valid = 1'b0;
		inject_flit = '0;
		ser_in = 1'b1;
		ser_ready = 1'b1;
		credit_hold = 1'b0;
		credit_delay = 3;
		inj_credits = BUF_DEPTH;
		seed = 32'h0b1f7a8d;
		for (i = 0; i < NUM_ENTRIES; i++)
		begin
			rnd = $random(seed);
			stim[i].src = SRC_DEST[i][2];
			stim[i].flit.dest = SRC_DEST[i][1:0];
			stim[i].flit.payload = rnd[PAYLOAD_W-1:0];
		end
		repeat (5) @(posedge CLK);
		#1;
		RST_N = 1'b0;

		err_mark = errors;
		repeat (20)
		begin
			@(negedge CLK);
			check(ser_out === 1'b1 && eject_valid === 1'b0 && inject_credit === 1'b0,
				"outputs active right after reset");
		end
		@(posedge CLK);
		#1;
		report_test("reset", err_mark);

		err_mark = errors;
		apply_entries(0, 11);
		wait_drained();
		report_test("routed traffic", err_mark);

		// link idle here so nothing is already on its way
		err_mark = errors;
		ser_ready = 1'b0;
		apply_entries(12, 15);
		repeat (3 * BIT_CYCLES)
		begin
			@(negedge CLK);
			check(ser_out === 1'b1, "frame started on ser_out while ser_ready was low");
		end
		@(posedge CLK);
		#1;
		ser_ready = 1'b1;
		wait_drained();
		report_test("serial back-pressure", err_mark);

		err_mark = errors;
		credit_hold = 1'b1;
		eject_mark = ejected;
		apply_entries(16, 19);
		repeat (50) @(posedge CLK);
		#1;
		check(ejected - eject_mark == EJECT_DEPTH,
			$sformatf("%0d flits ejected while credits were held", ejected - eject_mark));
		credit_delay = 0;
		credit_hold = 1'b0;
		wait_drained();
		report_test("eject back-pressure", err_mark);

		err_mark = errors;
		check(credit_pulses == local_sent,
			$sformatf("%0d inject credits for %0d flits", credit_pulses, local_sent));
		report_test("inject credits", err_mark);

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/noc_pkg.sv
hw/baud_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/flit_fifo.sv
hw/router_core.sv
hw/serial_node.sv
verification/serial_node_tb.sv
